//--- dv/rvv_tb.sv
`timescale 1ns/1ps

module rvv_tb;

    localparam int CMD_DEPTH = 4;
    localparam int TIMEOUT   = 50;  // Cycles per wait loop

    logic                 clk;
    logic                 rst;
    logic                 cmd_valid;
    rvv_pkg::rvv_req_t    cmd;
    logic                 cmd_credit;
    logic                 host_wr_valid;
    rvv_pkg::host_wr_t    host_wr;
    logic                 host_wr_ready;
    logic                 result_valid;
    rvv_pkg::rvv_result_t result;

    rvv_core #(.CMD_DEPTH(CMD_DEPTH)) rvv_core_i (.*);

    logic [63:0]          regs_m [32];  // Register model
    logic [8:0]           vl_m;
    rvv_pkg::vtype_t      vt_m;
    rvv_pkg::rvv_result_t exp_q [$];
    logic                 wr_q [$];     // Result came from a register write
    int                   credits;
    int                   credit_pulses;
    logic                 ready_prev;   // host_wr_ready of the cycle before
    logic [15:0]          lfsr;
    string                test_name;

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    //////////////////// Reference model
    // Fibonacci LFSR x^16 + x^14 + x^13 + x^11 + 1
    function automatic logic [63:0] rand_bits(input int n);
        logic [63:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            lfsr = {lfsr[14:0], lfsr[15] ^ lfsr[13] ^ lfsr[12] ^ lfsr[10]};
            v    = {v[62:0], lfsr[0]};
        end
        return v;
    endfunction

    function automatic int vlmax_of(input int sew, input int lmul);
        return (64 / (8 << sew)) * (1 << lmul);  // 64 / SEW * LMUL
    endfunction

    function automatic logic [63:0] broadcast(input logic [31:0] s, input int sew_bits);
        logic [63:0] v;
        if (sew_bits == 64) begin
            return {{32{s[31]}}, s};
        end
        v = '0;
        for (int i = 0; i < 64; i += sew_bits) begin
            v |= (64'(s) & ((64'd1 << sew_bits) - 64'd1)) << i;
        end
        return v;
    endfunction

    function automatic logic [63:0] ref_lanes(input rvv_pkg::valu_op_e op, input int sew_bits,
                                              input int vl, input logic [63:0] a,
                                              input logic [63:0] b, input logic [63:0] old);
        logic [63:0]        m;
        logic [63:0]        x;
        logic [63:0]        y;
        logic [63:0]        r;
        logic [63:0]        out;
        logic signed [63:0] sx;
        logic signed [63:0] sy;
        out = old;  // Tail undisturbed
        m   = (sew_bits == 64) ? '1 : (64'd1 << sew_bits) - 64'd1;
        for (int i = 0; i < 64 / sew_bits && i < vl; i++) begin
            x  = (a >> (i * sew_bits)) & m;
            y  = (b >> (i * sew_bits)) & m;
            sx = $signed(x | (x[sew_bits-1] ? ~m : 64'd0));
            sy = $signed(y | (y[sew_bits-1] ? ~m : 64'd0));
            case (op)
                rvv_pkg::OP_ADD: r = x + y;
                rvv_pkg::OP_SUB: r = x - y;
                rvv_pkg::OP_AND: r = x & y;
                rvv_pkg::OP_OR:  r = x | y;
                rvv_pkg::OP_XOR: r = x ^ y;
                rvv_pkg::OP_MIN: r = (sx < sy) ? x : y;
                default:         r = (sx > sy) ? x : y;
            endcase
            out = (out & ~(m << (i * sew_bits))) | ((r & m) << (i * sew_bits));
        end
        return out;
    endfunction

    function automatic rvv_pkg::rvv_req_t cfg_cmd(input int avl, input int sew, input int lmul);
        rvv_pkg::rvv_req_t r;
        r                  = '0;
        r.cmd.cfg.kind     = rvv_pkg::KIND_CFG;
        r.cmd.cfg.avl      = 9'(avl);
        r.cmd.cfg.sew_enc  = 3'(sew);
        r.cmd.cfg.lmul_enc = 3'(lmul);
        return r;
    endfunction

    function automatic rvv_pkg::rvv_req_t arith_cmd(input rvv_pkg::valu_op_e op, input int vd,
                                                    input int vs1, input int vs2,
                                                    input logic use_s, input logic [31:0] s);
        rvv_pkg::rvv_req_t r;
        r                      = '0;
        r.cmd.arith.kind       = rvv_pkg::KIND_ARITH;
        r.cmd.arith.op         = op;
        r.cmd.arith.vd         = 5'(vd);
        r.cmd.arith.vs1        = 5'(vs1);
        r.cmd.arith.vs2        = 5'(vs2);
        r.cmd.arith.use_scalar = use_s;
        r.scalar               = s;
        return r;
    endfunction

    //////////////////// Driving and checking
    task automatic abort_run(input string msg);
        $display("%s", msg);
        $display("Simulation FAILED");
        $fatal(1);
    endtask

    task automatic report_mismatch(input string what, input logic [63:0] exp_v,
                                   input logic [63:0] act_v);
        abort_run($sformatf("error [%s] %s: expected %h, actual %h",
                            test_name, what, exp_v, act_v));
    endtask

    task automatic check_result();
        rvv_pkg::rvv_result_t e;
        logic                 w;
        assert (exp_q.size() > 0) else abort_run("result_valid with no command outstanding");
        e = exp_q.pop_front();
        w = wr_q.pop_front();
        assert (result.kind == e.kind) else report_mismatch("kind", 64'(e.kind), 64'(result.kind));
        assert (result.vd == e.vd) else report_mismatch("vd", 64'(e.vd), 64'(result.vd));
        assert (result.data == e.data) else report_mismatch("data", e.data, result.data);
        if (w) begin
            assert (!ready_prev) else abort_run("host_wr_ready high during an ALU writeback");
        end
    endtask

    // Outputs sampled and inputs driven 1 ns after the edge
    task automatic tick();
        ready_prev = host_wr_ready;
        @(posedge clk);
        #1;
        if (cmd_credit) begin
            credits++;
            credit_pulses++;
            assert (credits <= CMD_DEPTH) else abort_run("credit returned beyond the queue depth");
        end
        if (result_valid) begin
            check_result();
        end
    endtask

    task automatic send_cmd(input rvv_pkg::rvv_req_t r);
        rvv_pkg::rvv_result_t     e;
        rvv_pkg::rvv_arith_view_t ar;
        logic [63:0]              opb;
        int                       vmax;
        int                       n;
        n = 0;
        while (credits == 0) begin
            tick();
            n++;
            if (n > TIMEOUT) abort_run("timeout waiting for a command credit");
        end
        ar     = r.cmd.arith;
        e      = '0;
        e.kind = r.cmd.cfg.kind;
        if (r.cmd.cfg.kind == rvv_pkg::KIND_CFG) begin
            vt_m.vill     = (r.cmd.cfg.sew_enc > 3'd3) || (r.cmd.cfg.lmul_enc > 3'd3);
            vt_m.sew_enc  = r.cmd.cfg.sew_enc;
            vt_m.lmul_enc = r.cmd.cfg.lmul_enc;
            vmax          = vlmax_of(r.cmd.cfg.sew_enc, r.cmd.cfg.lmul_enc);
            vl_m          = vt_m.vill ? 9'd0 : 9'((r.cmd.cfg.avl < vmax) ? r.cmd.cfg.avl : vmax);
            e.data        = 64'(vl_m);
            wr_q.push_back(1'b0);
        end else begin
            e.vd = ar.vd;
            if (!vt_m.vill) begin  // Under vill the result stays zero
                opb    = ar.use_scalar ? broadcast(r.scalar, 8 << vt_m.sew_enc) : regs_m[ar.vs1];
                e.data = ref_lanes(ar.op, 8 << vt_m.sew_enc, vl_m, regs_m[ar.vs2], opb,
                                   regs_m[ar.vd]);
                regs_m[ar.vd] = e.data;
            end
            wr_q.push_back(!vt_m.vill);
        end
        exp_q.push_back(e);
        cmd_valid = 1'b1;
        cmd       = r;
        credits--;
        tick();
        cmd_valid = 1'b0;
    endtask

    task automatic host_load(input int addr, input logic [63:0] data);
        int n;
        n             = 0;
        host_wr_valid = 1'b1;
        host_wr       = '{addr: 5'(addr), data: data};
        while (!host_wr_ready) begin
            tick();
            n++;
            if (n > TIMEOUT) abort_run("timeout waiting for host_wr_ready");
        end
        tick();
        host_wr_valid = 1'b0;
        regs_m[addr]  = data;
    endtask

    task automatic drain();
        int n;
        n = 0;
        while (exp_q.size() > 0) begin
            tick();
            n++;
            if (n > TIMEOUT) abort_run("timeout waiting for result_valid");
        end
    endtask

    task automatic reset_dut();
        rst           = 1'b0;
        cmd_valid     = 1'b0;
        host_wr_valid = 1'b0;
        repeat (2) tick();
        assert (!cmd_credit && !result_valid && !host_wr_ready)
            else abort_run("cmd_credit, result_valid or host_wr_ready high in reset");
        rst = 1'b1;
        foreach (regs_m[i]) begin
            regs_m[i] = '0;
        end
        vl_m          = '0;
        vt_m          = '{vill: 1'b1, sew_enc: 3'd0, lmul_enc: 3'd0};
        credits       = CMD_DEPTH;
        credit_pulses = 0;
    endtask

    //////////////////// Tests
    task automatic test_config();
        int vmax;
        int avls [5];
        test_name = "config";
        send_cmd(arith_cmd(rvv_pkg::OP_ADD, 3, 1, 2, 1'b0, '0));  // Reset leaves vill set
        for (int s = 0; s < 4; s++) begin
            for (int l = 0; l < 4; l++) begin
                vmax = vlmax_of(s, l);
                avls = '{0, vmax - 1, vmax, vmax + 1, 511};
                foreach (avls[i]) begin
                    send_cmd(cfg_cmd(avls[i], s, l));
                end
            end
        end
        send_cmd(cfg_cmd(10, 5, 0));  // Reserved SEW
        send_cmd(arith_cmd(rvv_pkg::OP_ADD, 3, 1, 2, 1'b0, '0));
        send_cmd(cfg_cmd(10, 0, 6));  // Reserved LMUL
        send_cmd(arith_cmd(rvv_pkg::OP_ADD, 3, 1, 2, 1'b1, 32'h1234));
        drain();
    endtask

    task automatic test_arith();
        test_name = "arith";
        for (int s = 0; s < 4; s++) begin
            send_cmd(cfg_cmd(vlmax_of(s, 0), s, 0));
            for (int op = 0; op < 7; op++) begin
                send_cmd(arith_cmd(rvv_pkg::valu_op_e'(op), 8 + op, 1 + s, 5 + s, 1'b0, '0));
            end
        end
        drain();
    endtask

    task automatic test_scalar_tail();
        test_name = "scalar_tail";
        for (int s = 0; s < 4; s++) begin
            send_cmd(cfg_cmd(vlmax_of(s, 0) / 2, s, 0));  // Half the lanes are tail
            send_cmd(arith_cmd(rvv_pkg::OP_ADD, 16 + s, 0, 2, 1'b1, 32'(rand_bits(32))));
            send_cmd(arith_cmd(rvv_pkg::OP_MAX, 20 + s, 0, 3, 1'b1, 32'(rand_bits(32))));
        end
        send_cmd(cfg_cmd(1, 3, 0));
        send_cmd(arith_cmd(rvv_pkg::OP_SUB, 24, 0, 4, 1'b1, 32'h8000_0001));  // Negative scalar
        drain();
    endtask

    task automatic test_chain();
        test_name = "chain";
        send_cmd(cfg_cmd(511, 1, 1));
        send_cmd(arith_cmd(rvv_pkg::OP_ADD, 25, 1, 2, 1'b0, '0));
        send_cmd(arith_cmd(rvv_pkg::OP_SUB, 26, 3, 25, 1'b0, '0));
        send_cmd(arith_cmd(rvv_pkg::OP_MIN, 27, 4, 26, 1'b0, '0));
        send_cmd(arith_cmd(rvv_pkg::OP_OR, 28, 5, 27, 1'b0, '0));
        send_cmd(cfg_cmd(1, 2, 0));  // New vl used by the very next add
        send_cmd(arith_cmd(rvv_pkg::OP_ADD, 28, 0, 28, 1'b1, 32'(rand_bits(32))));
        send_cmd(arith_cmd(rvv_pkg::OP_MAX, 28, 28, 27, 1'b0, '0));
        drain();
    endtask

    task automatic test_credit();
        test_name = "credit";
        reset_dut();
        host_wr_valid = 1'b1;  // Host keeps asking while writebacks run
        host_wr       = '{addr: 5'd30, data: rand_bits(64)};
        regs_m[30]    = host_wr.data;
        send_cmd(cfg_cmd(3, 0, 0));
        for (int i = 1; i < CMD_DEPTH; i++) begin
            send_cmd(arith_cmd(rvv_pkg::OP_ADD, i, 0, i - 1, 1'b1, 32'(rand_bits(32))));
        end
        drain();
        repeat (4) tick();  // No extra result may follow
        host_wr_valid = 1'b0;
        assert (credit_pulses == CMD_DEPTH)
            else report_mismatch("credit pulses", CMD_DEPTH, credit_pulses);
    endtask

    initial begin
        rst           = 1'b0;
        cmd_valid     = 1'b0;
        cmd           = '0;
        host_wr_valid = 1'b0;
        host_wr       = '0;
        lfsr          = 16'd21808;
        credits       = 0;
        credit_pulses = 0;
        ready_prev    = 1'b0;
        test_name     = "host_load";
        reset_dut();
        for (int i = 1; i < 32; i++) begin
            host_load(i, rand_bits(64));
        end
        test_config();
        test_arith();
        test_scalar_tail();
        test_chain();
        test_credit();
        $display("Simulation PASSED");
        $finish;
    end

endmodule

//--- project.f
verilog/rvv_pkg.sv
verilog/vtype_decoder.sv
verilog/vec_regfile.sv
verilog/vec_alu.sv
verilog/wb_arbiter.sv
verilog/rvv_core.sv
dv/rvv_tb.sv

//--- run.sh
#!/usr/bin/env bash
# Build and run the rvv_core testbench with Verilator
set -u

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --timescale 1ns/1ps -Wno-fatal \
    --top-module rvv_tb -f project.f --Mdir obj_dir
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

sim_out=$(./obj_dir/Vrvv_tb 2>&1)
sim_status=$?
echo "$sim_out"
if [ $sim_status -ne 0 ]; then
    echo "Simulation exited with status $sim_status"
    exit 1
fi

if grep -q "Simulation PASSED" <<< "$sim_out"; then
    exit 0
fi
echo "Pass message not found in the simulation output"
exit 1

//--- verilog/rvv_core.sv
`timescale 1ns/1ps

module rvv_core #(
    parameter int CMD_DEPTH = 4
) (
    input  logic                 clk,
    input  logic                 rst,
    input  logic                 cmd_valid,
    input  rvv_pkg::rvv_req_t    cmd,
    output logic                 cmd_credit,
    input  logic                 host_wr_valid,
    input  rvv_pkg::host_wr_t    host_wr,
    output logic                 host_wr_ready,
    output logic                 result_valid,
    output rvv_pkg::rvv_result_t result
);

    localparam int PTR_W = (CMD_DEPTH > 1) ? $clog2(CMD_DEPTH) : 1;
    localparam int CNT_W = $clog2(CMD_DEPTH + 1);

    typedef struct packed {
        rvv_pkg::rvv_kind_e         kind;
        rvv_pkg::valu_op_e          op;
        logic [4:0]                 vd;
        logic                       use_scalar;
        logic [31:0]                scalar;
        logic [rvv_pkg::XLEN_V-1:0] a;
        logic [rvv_pkg::XLEN_V-1:0] b;
        logic [rvv_pkg::XLEN_V-1:0] old_vd;
        logic [rvv_pkg::AVL_W-1:0]  vl;
        rvv_pkg::vtype_t            vt;
    } id_ex_t;

    //////////////////// Command queue
    rvv_pkg::rvv_req_t cmd_q [CMD_DEPTH];
    logic [PTR_W-1:0]  wr_ptr;
    logic [PTR_W-1:0]  rd_ptr;
    logic [CNT_W-1:0]  count;
    logic              pop;

    assign pop        = (count != '0);  // Host never overruns its credits
    assign cmd_credit = pop;

    always_ff @(posedge clk) begin
        if (cmd_valid) begin
            cmd_q[wr_ptr] <= cmd;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (cmd_valid) begin
                wr_ptr <= (wr_ptr == PTR_W'(CMD_DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            end
            if (pop) begin
                rd_ptr <= (rd_ptr == PTR_W'(CMD_DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            end
            case ({cmd_valid, pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    //////////////////// ID stage
    rvv_pkg::rvv_req_t          id_req;
    rvv_pkg::rvv_cfg_view_t     id_cfg;
    rvv_pkg::rvv_arith_view_t   id_ar;
    logic [rvv_pkg::AVL_W-1:0]  dec_vl;
    logic                       dec_vill;
    logic [4:0]                 ra_b;
    logic [rvv_pkg::XLEN_V-1:0] rd_a, rd_b, fwd_a, fwd_b;
    logic [rvv_pkg::AVL_W-1:0]  vl_q, eff_vl;
    rvv_pkg::vtype_t            vtype_q, eff_vt;
    logic                       ex_valid, ex_cfg, ex_wr;
    id_ex_t                     ex;
    logic [rvv_pkg::XLEN_V-1:0] alu_res;

    assign id_req = cmd_q[rd_ptr];
    assign id_cfg = id_req.cmd.cfg;
    assign id_ar  = id_req.cmd.arith;

    vtype_decoder vtype_decoder_i (
        .sew_enc  (id_cfg.sew_enc),
        .lmul_enc (id_cfg.lmul_enc),
        .avl      (id_cfg.avl),
        .vl       (dec_vl),
        .vill     (dec_vill)
    );

    // Scalar ops free port B for the old vd
    assign ra_b = id_ar.use_scalar ? id_ar.vd : id_ar.vs1;

    assign fwd_a = (ex_wr && ex.vd == id_ar.vs2) ? alu_res : rd_a;  // EX to ID bypass
    assign fwd_b = (ex_wr && ex.vd == ra_b) ? alu_res : rd_b;

    // A config in EX takes effect for the command right behind it
    assign eff_vl = (ex_valid && ex_cfg) ? ex.vl : vl_q;
    assign eff_vt = (ex_valid && ex_cfg) ? ex.vt : vtype_q;

    always_ff @(posedge clk) begin
        if (!rst) begin
            ex_valid <= 1'b0;
        end else begin
            ex_valid <= pop;
        end
    end

    always_ff @(posedge clk) begin
        ex.kind       <= id_cfg.kind;
        ex.op         <= id_ar.op;
        ex.vd         <= (id_cfg.kind == rvv_pkg::KIND_ARITH) ? id_ar.vd : 5'd0;
        ex.use_scalar <= id_ar.use_scalar;
        ex.scalar     <= id_req.scalar;
        ex.a          <= fwd_a;
        ex.b          <= fwd_b;
        // Two read ports only, vector-vector tail comes from vs1 or vs2
        ex.old_vd     <= (id_ar.use_scalar || id_ar.vd == id_ar.vs1) ? fwd_b : fwd_a;
        if (id_cfg.kind == rvv_pkg::KIND_CFG) begin
            ex.vl <= dec_vl;
            ex.vt <= '{vill: dec_vill, sew_enc: id_cfg.sew_enc, lmul_enc: id_cfg.lmul_enc};
        end else begin
            ex.vl <= eff_vl;
            ex.vt <= eff_vt;
        end
    end

    //////////////////// EX stage
    logic                       rf_we;
    logic [4:0]                 rf_wa;
    logic [rvv_pkg::XLEN_V-1:0] rf_wd;
    logic [rvv_pkg::XLEN_V-1:0] ex_data;

    assign ex_cfg = (ex.kind == rvv_pkg::KIND_CFG);
    assign ex_wr  = ex_valid && ex.kind == rvv_pkg::KIND_ARITH && !ex.vt.vill;

    vec_alu vec_alu_i (
        .op         (ex.op),
        .sew_enc    (ex.vt.sew_enc),
        .vl         (ex.vl),
        .src_a      (ex.a),
        .src_b      (ex.b),
        .scalar     (ex.scalar),
        .use_scalar (ex.use_scalar),
        .old_vd     (ex.old_vd),
        .res        (alu_res)
    );

    wb_arbiter wb_arbiter_i (
        .clk           (clk),
        .rst           (rst),
        .alu_we        (ex_wr),
        .alu_wa        (ex.vd),
        .alu_wd        (alu_res),
        .host_wr_valid (host_wr_valid),
        .host_wr       (host_wr),
        .host_wr_ready (host_wr_ready),
        .we            (rf_we),
        .wa            (rf_wa),
        .wd            (rf_wd)
    );

    vec_regfile vec_regfile_i (
        .clk  (clk),
        .rst  (rst),
        .ra_a (id_ar.vs2),
        .ra_b (ra_b),
        .rd_a (rd_a),
        .rd_b (rd_b),
        .we   (rf_we),
        .wa   (rf_wa),
        .wd   (rf_wd)
    );

    // Config reports vl, arithmetic under vill reports zeros
    assign ex_data = ex_cfg ? rvv_pkg::XLEN_V'(ex.vl) : (ex_wr ? alu_res : '0);

    always_ff @(posedge clk) begin
        if (!rst) begin
            result_valid <= 1'b0;
            vl_q         <= '0;
            vtype_q      <= '{vill: 1'b1, sew_enc: 3'd0, lmul_enc: 3'd0};
        end else begin
            result_valid <= ex_valid;
            if (ex_valid && ex_cfg) begin
                vl_q    <= ex.vl;
                vtype_q <= ex.vt;
            end
        end
    end

    always_ff @(posedge clk) begin
        result <= '{kind: ex.kind, vd: ex.vd, data: ex_data};
    end

endmodule

//--- verilog/rvv_pkg.sv
package rvv_pkg;

    localparam int XLEN_V = 64;  // Vector register width
    localparam int AVL_W  = 9;   // AVL and vl width
    localparam int NREGS  = 32;

    // SEW encodings
    localparam logic [2:0] SEW_E8  = 3'd0;
    localparam logic [2:0] SEW_E16 = 3'd1;
    localparam logic [2:0] SEW_E32 = 3'd2;
    localparam logic [2:0] SEW_E64 = 3'd3;

    // LMUL encodings, integer multipliers only
    localparam logic [2:0] LMUL_M1 = 3'd0;
    localparam logic [2:0] LMUL_M2 = 3'd1;
    localparam logic [2:0] LMUL_M4 = 3'd2;
    localparam logic [2:0] LMUL_M8 = 3'd3;

    typedef enum logic [1:0] {
        KIND_CFG   = 2'd1,  // vsetvli style
        KIND_ARITH = 2'd2   // Vector ALU op
    } rvv_kind_e;

    typedef enum logic [2:0] {
        OP_ADD = 3'd0,
        OP_SUB = 3'd1,
        OP_AND = 3'd2,
        OP_OR  = 3'd3,
        OP_XOR = 3'd4,
        OP_MIN = 3'd5,
        OP_MAX = 3'd6
    } valu_op_e;

    typedef struct packed {
        rvv_kind_e   kind;
        logic [8:0]  avl;
        logic [2:0]  sew_enc;
        logic [2:0]  lmul_enc;
        logic [14:0] spare;
    } rvv_cfg_view_t;

    typedef struct packed {
        rvv_kind_e   kind;
        valu_op_e    op;
        logic [4:0]  vd;
        logic [4:0]  vs1;
        logic [4:0]  vs2;
        logic        use_scalar;
        logic [10:0] spare;
    } rvv_arith_view_t;

    // Same word, decoded by kind
    typedef union packed {
        rvv_cfg_view_t   cfg;
        rvv_arith_view_t arith;
    } rvv_cmd_u;

    typedef struct packed {
        rvv_cmd_u    cmd;
        logic [31:0] scalar;
    } rvv_req_t;

    typedef struct packed {
        logic       vill;
        logic [2:0] sew_enc;
        logic [2:0] lmul_enc;
    } vtype_t;

    typedef struct packed {
        rvv_kind_e         kind;
        logic [4:0]        vd;
        logic [XLEN_V-1:0] data;
    } rvv_result_t;

    typedef struct packed {
        logic [4:0]        addr;
        logic [XLEN_V-1:0] data;
    } host_wr_t;

endpackage

//--- verilog/vec_alu.sv
`timescale 1ns/1ps

module vec_alu (
    input  rvv_pkg::valu_op_e         op,
    input  logic [2:0]                sew_enc,
    input  logic [rvv_pkg::AVL_W-1:0]  vl,
    input  logic [rvv_pkg::XLEN_V-1:0] src_a,
    input  logic [rvv_pkg::XLEN_V-1:0] src_b,
    input  logic [31:0]               scalar,
    input  logic                      use_scalar,
    input  logic [rvv_pkg::XLEN_V-1:0] old_vd,
    output logic [rvv_pkg::XLEN_V-1:0] res
);

    // One lane op on the low w bits of a and b
    function automatic logic [63:0] lane_op(
        input rvv_pkg::valu_op_e f,
        input logic [63:0]       a,
        input logic [63:0]       b,
        input logic [6:0]        w
    );
        logic signed [63:0] sa;
        logic signed [63:0] sb;
        sa = $signed(a << (7'd64 - w));  // Lane sign bit moved to bit 63
        sb = $signed(b << (7'd64 - w));
        case (f)
            rvv_pkg::OP_ADD: lane_op = a + b;
            rvv_pkg::OP_SUB: lane_op = a - b;
            rvv_pkg::OP_AND: lane_op = a & b;
            rvv_pkg::OP_OR:  lane_op = a | b;
            rvv_pkg::OP_XOR: lane_op = a ^ b;
            rvv_pkg::OP_MIN: lane_op = (sa < sb) ? a : b;
            rvv_pkg::OP_MAX: lane_op = (sa > sb) ? a : b;
            default:         lane_op = a;
        endcase
    endfunction

    logic [6:0]  w;       // SEW in bits
    logic [3:0]  lanes;
    logic [63:0] mask;
    logic [63:0] bcast;
    logic [63:0] op_b;
    logic [6:0]  sh;
    logic [63:0] lane;

    always_comb begin
        w     = 7'd8 << sew_enc[1:0];
        lanes = 4'd8 >> sew_enc[1:0];
        mask  = (w == 7'd64) ? '1 : ((64'd1 << w) - 64'd1);

        case (sew_enc[1:0])
            2'd0:    bcast = {8{scalar[7:0]}};
            2'd1:    bcast = {4{scalar[15:0]}};
            2'd2:    bcast = {2{scalar}};
            default: bcast = {{32{scalar[31]}}, scalar};  // Sign-extended for SEW 64
        endcase
        op_b = use_scalar ? bcast : src_b;

        // Tail lanes keep the old destination
        res  = old_vd;
        sh   = '0;
        lane = '0;
        for (int k = 0; k < 8; k++) begin
            if (!sew_enc[2] && k < lanes && k < vl) begin
                sh   = w * 7'(k);
                lane = lane_op(op, src_a >> sh, op_b >> sh, w) & mask;
                res  = (res & ~(mask << sh)) | (lane << sh);
            end
        end
    end

endmodule

//--- verilog/vec_regfile.sv
`timescale 1ns/1ps

module vec_regfile (
    input  logic                      clk,
    input  logic                      rst,
    input  logic [4:0]                ra_a,
    input  logic [4:0]                ra_b,
    output logic [rvv_pkg::XLEN_V-1:0] rd_a,
    output logic [rvv_pkg::XLEN_V-1:0] rd_b,
    input  logic                      we,
    input  logic [4:0]                wa,
    input  logic [rvv_pkg::XLEN_V-1:0] wd
);

    logic [rvv_pkg::XLEN_V-1:0] regs [rvv_pkg::NREGS];

    always_ff @(posedge clk) begin
        if (!rst) begin
            for (int i = 0; i < rvv_pkg::NREGS; i++) begin
                regs[i] <= '0;
            end
        end else if (we) begin
            regs[wa] <= wd;  // Visible to readers next cycle
        end
    end

    // Asynchronous reads, same-cycle write not bypassed here
    assign rd_a = regs[ra_a];
    assign rd_b = regs[ra_b];

endmodule

//--- verilog/vtype_decoder.sv
`timescale 1ns/1ps

module vtype_decoder (
    input  logic [2:0]               sew_enc,
    input  logic [2:0]               lmul_enc,
    input  logic [rvv_pkg::AVL_W-1:0] avl,
    output logic [rvv_pkg::AVL_W-1:0] vl,
    output logic                     vill
);

    logic [3:0]               lanes;    // Elements per 64-bit register
    logic [1:0]               lmul_sh;  // log2 of LMUL
    logic                     sew_ok;
    logic                     lmul_ok;
    logic [rvv_pkg::AVL_W-1:0] vlmax;

    always_comb begin
        lanes   = 4'd0;
        lmul_sh = 2'd0;
        sew_ok  = 1'b1;
        lmul_ok = 1'b1;

        case (sew_enc)
            rvv_pkg::SEW_E8:  lanes = 4'd8;
            rvv_pkg::SEW_E16: lanes = 4'd4;
            rvv_pkg::SEW_E32: lanes = 4'd2;
            rvv_pkg::SEW_E64: lanes = 4'd1;
            default:          sew_ok = 1'b0;
        endcase

        case (lmul_enc)
            rvv_pkg::LMUL_M1: lmul_sh = 2'd0;
            rvv_pkg::LMUL_M2: lmul_sh = 2'd1;
            rvv_pkg::LMUL_M4: lmul_sh = 2'd2;
            rvv_pkg::LMUL_M8: lmul_sh = 2'd3;
            default:          lmul_ok = 1'b0;
        endcase

        // VLMAX = (64 / SEW) * LMUL, at most 64
        vlmax = rvv_pkg::AVL_W'(lanes) << lmul_sh;
        vill  = !(sew_ok && lmul_ok);

        if (vill) begin
            vl = '0;  // Illegal vtype clears vl
        end else if (avl < vlmax) begin
            vl = avl;
        end else begin
            vl = vlmax;
        end
    end

endmodule

//--- verilog/wb_arbiter.sv
`timescale 1ns/1ps

module wb_arbiter (
    input  logic                      clk,
    input  logic                      rst,
    input  logic                      alu_we,
    input  logic [4:0]                alu_wa,
    input  logic [rvv_pkg::XLEN_V-1:0] alu_wd,
    input  logic                      host_wr_valid,
    input  rvv_pkg::host_wr_t         host_wr,
    output logic                      host_wr_ready,
    output logic                      we,
    output logic [4:0]                wa,
    output logic [rvv_pkg::XLEN_V-1:0] wd
);

    logic rdy_en_q;  // Host grant enable, held off through reset
    logic host_go;

    always_ff @(posedge clk) begin
        if (!rst) begin
            rdy_en_q <= 1'b0;
        end else begin
            rdy_en_q <= 1'b1;
        end
    end

    // ALU writeback always wins, alu_we comes from a register
    assign host_wr_ready = rdy_en_q && !alu_we;
    assign host_go       = host_wr_valid && host_wr_ready;

    assign we = alu_we || host_go;
    assign wa = alu_we ? alu_wa : host_wr.addr;
    assign wd = alu_we ? alu_wd : host_wr.data;

endmodule
